// File: mul_core.f
hdl/mul_pkg.sv
hdl/mul_pipe.sv
hdl/mul_unit.sv
hdl/hilo_regs.sv
hdl/mul_core_top.sv
tb/tb_mul_core.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# A failing test ends in $fatal, which gives a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mul_core \
    -f mul_core.f \
    -o sim_tb_mul_core

./obj_dir/sim_tb_mul_core

// File: tb/tb_mul_core.sv
`timescale 1ns/1ps

module tb_mul_core;
    import mul_pkg::*;

    localparam int MUL_STAGES = 4;

    // Operation counts, used for the run length limit below.
    localparam int N_EXTREME    = 18;
    localparam int N_DIRECTED   = 4;
    localparam int N_RANDOM_MUL = 150;
    localparam int N_WRITES     = 40;
    localparam int NUM_OPS      = N_EXTREME + N_DIRECTED + N_RANDOM_MUL + N_WRITES;
    localparam int TIMEOUT_CYCLES = NUM_OPS * (MUL_STAGES + 4) + 50;

    logic  clk;
    logic  rst;
    word_t src_a;
    word_t src_b;
    logic  en;
    logic  mul_sign;
    word_t hilo_wdata;
    logic  hi_we;
    logic  lo_we;
    word_t hi;
    word_t lo;
    logic  stall_all;
    logic  res_ready;

    // Expected contents of the HI/LO pair.
    word_t exp_hi;
    word_t exp_lo;

    logic [31:0] lfsr_state;
    int          cycle_count;

    mul_core_top #(
        .MUL_STAGES (MUL_STAGES)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .src_a      (src_a),
        .src_b      (src_b),
        .en         (en),
        .mul_sign   (mul_sign),
        .hilo_wdata (hilo_wdata),
        .hi_we      (hi_we),
        .lo_we      (lo_we),
        .hi         (hi),
        .lo         (lo),
        .stall_all  (stall_all),
        .res_ready  (res_ready)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("tests failed");
            $fatal(1, "Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    // Galois LFSR with the feedback polynomial x^32 + x^30 + x^26 + x^25 + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ 32'hA300_0000;
        end
        return nxt;
    endfunction

    // Each bit taken costs one LFSR step.
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Operands lean towards the corner values that break sign handling.
    task automatic rand_operand(output word_t v);
        logic [31:0] sel;
        take_bits(3, sel);
        case (sel[2:0])
            3'd0: v = 32'h0000_0000;
            3'd1: v = 32'hFFFF_FFFF;
            3'd2: v = 32'h8000_0000;
            default: take_bits(32, v);
        endcase
    endtask

    function automatic word_t extreme_value(input int idx);
        case (idx)
            0: return 32'h0000_0000;
            1: return 32'hFFFF_FFFF;
            default: return 32'h8000_0000;
        endcase
    endfunction

    // Reference product. Both operands are widened to 64 bits, with sign
    // extension for a signed multiply, and the low 64 bits are kept.
    function automatic dword_t expected_product(input word_t a, input word_t b,
                                                input logic sgn);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        if (sgn) begin
            sa = {{32{a[31]}}, a};
            sb = {{32{b[31]}}, b};
        end else begin
            sa = {32'b0, a};
            sb = {32'b0, b};
        end
        return dword_t'(sa * sb);
    endfunction

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, msg, actual,
                     expected);
            $display("tests failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Called at a falling edge. busy_mode 1 holds en high with new operands
    // while busy, 2 pulses en at random, others leave en low. wr_mask puts
    // direct writes into the res_ready cycle. Returns at the falling edge
    // after hi and lo have been checked.
    task automatic run_mul(input word_t a, input word_t b, input logic sgn,
                           input logic [1:0] busy_mode, input logic [1:0] wr_mask);
        dword_t      prod;
        logic [31:0] rnd;
        word_t       noise;
        int          wait_cycles;
        prod = expected_product(a, b, sgn);
        src_a    = a;
        src_b    = b;
        mul_sign = sgn;
        en       = 1'b1;
        #1;
        check(stall_all, 1'b1, "stall_all in the en cycle");
        check(res_ready, 1'b0, "res_ready in the en cycle");
        @(negedge clk);
        // First falling edge after the start edge.
        wait_cycles = 0;
        while (!res_ready) begin
            check(stall_all, 1'b1, "stall_all while the product is in flight");
            if (busy_mode == 2'd1) begin
                en = 1'b1;
                rand_operand(noise);
                src_a = noise;
                rand_operand(noise);
                src_b = noise;
            end else if (busy_mode == 2'd2) begin
                take_bits(2, rnd);
                en       = rnd[0];
                mul_sign = rnd[1];
                rand_operand(noise);
                src_a = noise;
                rand_operand(noise);
                src_b = noise;
            end else begin
                en = 1'b0;
            end
            @(negedge clk);
            wait_cycles++;
        end
        check(wait_cycles, MUL_STAGES, "res_ready latency after the start edge");
        check(stall_all, 1'b0, "stall_all in the res_ready cycle");
        en = 1'b0;
        take_bits(32, rnd);
        hilo_wdata = rnd;
        hi_we      = wr_mask[1];
        lo_we      = wr_mask[0];
        @(negedge clk);
        hi_we = 1'b0;
        lo_we = 1'b0;
        check(res_ready, 1'b0, "res_ready longer than one cycle");
        // The product wins over any direct write in the res_ready cycle.
        exp_hi = prod[63:32];
        exp_lo = prod[31:0];
        check(hi, exp_hi, "hi after multiply");
        check(lo, exp_lo, "lo after multiply");
    endtask

    // Called at a falling edge, returns at the next one.
    task automatic direct_write(input word_t data, input logic wr_hi, input logic wr_lo);
        hilo_wdata = data;
        hi_we      = wr_hi;
        lo_we      = wr_lo;
        @(negedge clk);
        hi_we = 1'b0;
        lo_we = 1'b0;
        if (wr_hi) begin
            exp_hi = data;
        end
        if (wr_lo) begin
            exp_lo = data;
        end
        check(hi, exp_hi, "hi after direct write");
        check(lo, exp_lo, "lo after direct write");
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] mode;
        logic [31:0] mask;
        word_t       op_a;
        word_t       op_b;
        clk         = 1'b0;
        rst         = 1'b1;
        src_a       = '0;
        src_b       = '0;
        en          = 1'b0;
        mul_sign    = 1'b0;
        hilo_wdata  = '0;
        hi_we       = 1'b0;
        lo_we       = 1'b0;
        exp_hi      = '0;
        exp_lo      = '0;
        lfsr_state  = 32'd94067;
        cycle_count = 0;

        repeat (3) @(negedge clk);
        rst = 1'b0;

        check(stall_all, 1'b0, "stall_all after reset");
        check(res_ready, 1'b0, "res_ready after reset");
        check(hi, 32'h0, "hi after reset");
        check(lo, 32'h0, "lo after reset");

        // Every pairing of the corner operands, unsigned and signed.
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < 3; i++) begin
                for (int j = 0; j < 3; j++) begin
                    run_mul(extreme_value(i), extreme_value(j), s[0], 2'd0, 2'b00);
                end
            end
        end

        // Back to back starts with busy noise and a write collision.
        run_mul(32'h1234_5678, 32'h9ABC_DEF0, 1'b0, 2'd1, 2'b11);
        run_mul(32'hFFFF_FFFE, 32'h0000_0003, 1'b1, 2'd2, 2'b10);
        run_mul(32'h8000_0000, 32'h7FFF_FFFF, 1'b1, 2'd1, 2'b01);
        run_mul(32'hDEAD_BEEF, 32'hCAFE_F00D, 1'b0, 2'd2, 2'b11);

        for (int n = 0; n < N_RANDOM_MUL; n++) begin
            rand_operand(op_a);
            rand_operand(op_b);
            take_bits(1, rnd);
            take_bits(2, mode);
            take_bits(2, mask);
            run_mul(op_a, op_b, rnd[0], mode[1:0], mask[1:0]);
            take_bits(1, rnd);
            if (rnd[0]) begin
                @(negedge clk);
            end
        end

        for (int n = 0; n < N_WRITES; n++) begin
            take_bits(32, op_a);
            take_bits(2, mask);
            direct_write(op_a, mask[1], mask[0]);
        end

        check(stall_all, 1'b0, "stall_all at the end of the run");

        $display("all tests passed");
        $finish;
    end

endmodule

// File: hdl/mul_core_top.sv
`timescale 1ns/1ps

module mul_core_top #(
    parameter int MUL_STAGES = 4
) (
    input  logic           clk,
    input  logic           rst,
    input  mul_pkg::word_t src_a,
    input  mul_pkg::word_t src_b,
    input  logic           en,
    input  logic           mul_sign,
    input  mul_pkg::word_t hilo_wdata,
    input  logic           hi_we,
    input  logic           lo_we,
    output mul_pkg::word_t hi,
    output mul_pkg::word_t lo,
    output logic           stall_all,
    output logic           res_ready
);
    import mul_pkg::*;

    // Product halves on their way into the HI/LO pair.
    word_t prod_hi;
    word_t prod_lo;

    mul_unit #(
        .MUL_STAGES (MUL_STAGES)
    ) u_mul_unit (
        .clk       (clk),
        .rst       (rst),
        .src_a     (src_a),
        .src_b     (src_b),
        .en        (en),
        .mul_sign  (mul_sign),
        .s         (prod_lo),
        .r         (prod_hi),
        .res_ready (res_ready),
        .stall_all (stall_all)
    );

    // res_ready doubles as the load strobe of the register pair.
    hilo_regs u_hilo_regs (
        .clk        (clk),
        .rst        (rst),
        .res_ready  (res_ready),
        .r          (prod_hi),
        .s          (prod_lo),
        .hilo_wdata (hilo_wdata),
        .hi_we      (hi_we),
        .lo_we      (lo_we),
        .hi         (hi),
        .lo         (lo)
    );

endmodule

// File: hdl/hilo_regs.sv
`timescale 1ns/1ps

module hilo_regs (
    input  logic           clk,
    input  logic           rst,
    input  logic           res_ready,
    input  mul_pkg::word_t r,
    input  mul_pkg::word_t s,
    input  mul_pkg::word_t hilo_wdata,
    input  logic           hi_we,
    input  logic           lo_we,
    output mul_pkg::word_t hi,
    output mul_pkg::word_t lo
);

    // A finished product loads both halves and overrides any direct
    // write in the same cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
        end else if (res_ready) begin
            hi <= r;
        end else if (hi_we) begin
            hi <= hilo_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lo <= '0;
        end else if (res_ready) begin
            lo <= s;
        end else if (lo_we) begin
            lo <= hilo_wdata;
        end
    end

endmodule

// File: hdl/mul_unit.sv
`timescale 1ns/1ps

module mul_unit #(
    parameter int MUL_STAGES = 4
) (
    input  logic           clk,
    input  logic           rst,
    input  mul_pkg::word_t src_a,
    input  mul_pkg::word_t src_b,
    input  logic           en,
    input  logic           mul_sign,
    output mul_pkg::word_t s,
    output mul_pkg::word_t r,
    output logic           res_ready,
    output logic           stall_all
);
    import mul_pkg::*;

    // The counter must be able to hold MUL_STAGES itself.
    localparam int CNT_W = $clog2(MUL_STAGES + 1);

    mul_state_t state;
    mul_state_t next_state;

    logic [CNT_W-1:0] counter;
    logic [CNT_W-1:0] next_counter;

    logic start;

    // Operand magnitudes and the sign of the final product.
    word_t a_reg;
    word_t b_reg;
    logic  sign;

    dword_t prod;
    dword_t res;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= MUL_FREE;
            counter <= '0;
        end else begin
            state   <= next_state;
            counter <= next_counter;
        end
    end

    // A start is only taken while free, so a busy unit keeps the
    // operands of the product in flight.
    always_ff @(posedge clk) begin
        if (rst) begin
            a_reg <= '0;
            b_reg <= '0;
            sign  <= 1'b0;
        end else if (start) begin
            if (mul_sign) begin
                sign  <= src_a[WORD_W-1] ^ src_b[WORD_W-1];
                a_reg <= src_a[WORD_W-1] ? -src_a : src_a;
                b_reg <= src_b[WORD_W-1] ? -src_b : src_b;
            end else begin
                sign  <= 1'b0;
                a_reg <= src_a;
                b_reg <= src_b;
            end
        end
    end

    always_comb begin
        next_state   = state;
        next_counter = counter;
        start        = 1'b0;
        stall_all    = 1'b0;
        res_ready    = 1'b0;
        case (state)
            MUL_FREE: begin
                if (en) begin
                    start        = 1'b1;
                    stall_all    = 1'b1;
                    next_state   = MUL_RUNNING;
                    next_counter = CNT_W'(MUL_STAGES);
                end
            end
            MUL_RUNNING: begin
                if (counter == '0) begin
                    res_ready  = 1'b1;
                    next_state = MUL_FREE;
                end else begin
                    stall_all    = 1'b1;
                    next_counter = counter - 1'b1;
                end
            end
            default: begin
                next_state = MUL_FREE;
            end
        endcase
    end

    mul_pipe #(
        .MUL_STAGES (MUL_STAGES)
    ) u_pipe (
        .clk (clk),
        .rst (rst),
        .a   (a_reg),
        .b   (b_reg),
        .p   (prod)
    );

    // The pipeline only ever sees magnitudes; the sign goes back on here.
    assign res = sign ? -prod : prod;
    assign r   = res[DWORD_W-1:WORD_W];
    assign s   = res[WORD_W-1:0];

    // The stall covers the whole flight, from the en cycle to the cycle
    // before the pulse, and drops with it.
    a_ready_no_stall: assert property (@(posedge clk) disable iff (rst)
        res_ready |-> !stall_all && $past(stall_all) && $past(stall_all, MUL_STAGES + 1))
        else $error("stall_all does not cover the product in flight up to res_ready");

    a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        res_ready |=> !res_ready)
        else $error("res_ready held for more than one cycle");

    // The start is sampled at its edge, the pulse one edge after the
    // counter has run out.
    a_ready_latency: assert property (@(posedge clk) disable iff (rst)
        res_ready |-> $past(start, MUL_STAGES + 1))
        else $error("res_ready does not follow a start by MUL_STAGES cycles");

endmodule

// File: hdl/mul_pipe.sv
`timescale 1ns/1ps

module mul_pipe #(
    parameter int MUL_STAGES = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  mul_pkg::word_t  a,
    input  mul_pkg::word_t  b,
    output mul_pkg::dword_t p
);
    import mul_pkg::*;

    // Stage one holds the four 16 by 16 partial products.
    word_t pp_ll;
    word_t pp_lh;
    word_t pp_hl;
    word_t pp_hh;

    // Stage two and the delay chain behind it.
    // Entry 0 is the summed product, the last entry drives p.
    dword_t pipe_q [MUL_STAGES-1];

    dword_t sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            pp_ll <= '0;
            pp_lh <= '0;
            pp_hl <= '0;
            pp_hh <= '0;
        end else begin
            pp_ll <= word_t'(a[15:0])  * word_t'(b[15:0]);
            pp_lh <= word_t'(a[15:0])  * word_t'(b[31:16]);
            pp_hl <= word_t'(a[31:16]) * word_t'(b[15:0]);
            pp_hh <= word_t'(a[31:16]) * word_t'(b[31:16]);
        end
    end

    // The cross terms sit 16 bits up, the high term 32 bits up.
    always_comb begin
        sum = dword_t'(pp_ll)
            + (dword_t'(pp_lh) << 16)
            + (dword_t'(pp_hl) << 16)
            + (dword_t'(pp_hh) << 32);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MUL_STAGES - 1; i++) begin
                pipe_q[i] <= '0;
            end
        end else begin
            pipe_q[0] <= sum;
            for (int i = 1; i < MUL_STAGES - 1; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    assign p = pipe_q[MUL_STAGES-2];

    // The partial product and sum stages need two registers at least.
    a_min_stages: assert property (@(posedge clk) MUL_STAGES >= 2)
        else $error("mul_pipe needs MUL_STAGES of 2 or more");

endmodule

// File: hdl/mul_pkg.sv
package mul_pkg;

    // Width of one operand or one register of the HI/LO pair.
    localparam int WORD_W = 32;

    // The full product is twice as wide as an operand.
    localparam int DWORD_W = 2 * WORD_W;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [DWORD_W-1:0] dword_t;

    // Control states of the multiply unit.
    // MUL_FREE accepts a new start, MUL_RUNNING counts down the
    // pipeline latency and then releases the result.
    typedef enum logic [0:0] {
        MUL_FREE    = 1'b0,
        MUL_RUNNING = 1'b1
    } mul_state_t;

endpackage
